// File: common/rp_settings.svh
////////////////////////////////////////
// widths, bus region map, register offsets
// and the housekeeping id word
////////////////////////////////////////
`ifndef RP_SETTINGS_SVH
`define RP_SETTINGS_SVH

// analog widths
`define RP_ADC_PAD_W 16  // raw adc pad bus, low 2 bits reserved
`define RP_SMP_W     14  // converted sample width
`define RP_LED_W     8

// system bus
`define RP_BUS_AW      32
`define RP_BUS_DW      32
`define RP_REGIONS     8   // address space split in 8 regions
`define RP_REG_SEL_LSB 20  // region = addr[22:20]
`define RP_REG_SEL_MSB 22

// housekeeping, region 0
`define RP_HK_ID        32'h5250_0001  // board id, read only
`define RP_HK_ID_OFS    20'h00000
`define RP_HK_LOOP_OFS  20'h00004
`define RP_HK_LED_OFS   20'h00030
`define RP_HK_LVL_A_OFS 20'h00040
`define RP_HK_LVL_B_OFS 20'h00044

// adc monitor, region 1
`define RP_MON_A_OFS 20'h00000
`define RP_MON_B_OFS 20'h00004

`endif

// File: common/rp_bus_pkg.sv
////////////////////////////////////////
// system bus request/response structs
// and the region numbers
////////////////////////////////////////
`include "rp_settings.svh"

package rp_bus_pkg;

  // one bus access from the master
  // wen/ren are single cycle strobes, addr and wdata held until ack
  typedef struct packed {
    logic [`RP_BUS_AW-1:0] addr;   // byte address
    logic [`RP_BUS_DW-1:0] wdata;  // write data
    logic                  wen;    // write strobe
    logic                  ren;    // read strobe
  } sys_req_t;

  // slave answer, err only valid together with ack
  typedef struct packed {
    logic [`RP_BUS_DW-1:0] rdata;
    logic                  err;
    logic                  ack;
  } sys_rsp_t;

  // region number taken from addr[22:20]
  typedef enum logic [`RP_REG_SEL_MSB-`RP_REG_SEL_LSB:0] {
    REG_HK   = 0,  // housekeeping
    REG_MON  = 1,  // adc monitor
    REG_RSV2 = 2,
    REG_RSV3 = 3,
    REG_RSV4 = 4,
    REG_RSV5 = 5,
    REG_RSV6 = 6,
    REG_RSV7 = 7
  } region_e;

endpackage

// File: common/rp_analog_pkg.sv
////////////////////////////////////////
// sample and pad types, channel pairs, leds
////////////////////////////////////////
`include "rp_settings.svh"

package rp_analog_pkg;

  typedef logic signed [`RP_SMP_W-1:0] smp_t;  // two's complement
  typedef logic        [`RP_SMP_W-1:0] pad_t;  // negative slope offset code
  typedef logic        [`RP_LED_W-1:0] led_t;

  // both channels side by side, a in the upper half
  typedef struct packed {
    smp_t a;
    smp_t b;
  } smp_pair_t;

  typedef struct packed {
    pad_t a;
    pad_t b;
  } pad_pair_t;

  // negative slope code, msb kept, rest inverted
  // same bit operation in both directions
  function automatic smp_t pad_to_smp(pad_t p);
    return smp_t'({p[`RP_SMP_W-1], ~p[`RP_SMP_W-2:0]});
  endfunction

  function automatic pad_t smp_to_pad(smp_t s);
    return pad_t'({s[`RP_SMP_W-1], ~s[`RP_SMP_W-2:0]});
  endfunction

  // sign extend a sample to a bus word
  function automatic logic [`RP_BUS_DW-1:0] smp_to_word(smp_t s);
    return {{(`RP_BUS_DW-`RP_SMP_W){s[`RP_SMP_W-1]}}, s};
  endfunction

endpackage

// File: design/sys_bus_decoder.sv
////////////////////////////////////////
// system bus decoder, 8 regions by addr[22:20]
////////////////////////////////////////
`timescale 1ns/1ps
`include "rp_settings.svh"

module sys_bus_decoder (
  input  rp_bus_pkg::sys_req_t sys_req_i,                 // from bus master
  output rp_bus_pkg::sys_rsp_t sys_rsp_o,                 // back to bus master
  output rp_bus_pkg::sys_req_t reg_req_o [`RP_REGIONS],   // per region request
  input  rp_bus_pkg::sys_rsp_t reg_rsp_i [`RP_REGIONS]    // per region response
);

  import rp_bus_pkg::*;

  localparam logic [`RP_REGIONS-1:0] CS_ONE = 1;

  region_e                region;                  // selected region
  logic [`RP_REGIONS-1:0] reg_cs;                  // one-hot region select
  logic                   strobe;                  // any access this cycle
  sys_rsp_t               rsp_mux [`RP_REGIONS];   // responses incl. tie-offs

  ////////////////////////////////////////
  // region select
  ////////////////////////////////////////

  assign region = region_e'(sys_req_i.addr[`RP_REG_SEL_MSB:`RP_REG_SEL_LSB]);
  assign reg_cs = CS_ONE << region;
  assign strobe = sys_req_i.wen | sys_req_i.ren;

  ////////////////////////////////////////
  // request fan-out and response slots
  ////////////////////////////////////////

  for (genvar i = 0; i < `RP_REGIONS; i++)
  begin : g_region
    // address and data go everywhere, strobes only to the selected slave
    always_comb
    begin
      reg_req_o[i]     = sys_req_i;
      reg_req_o[i].wen = sys_req_i.wen & reg_cs[i];
      reg_req_o[i].ren = sys_req_i.ren & reg_cs[i];
    end

    if (i <= int'(REG_MON))
    begin : g_used
      assign rsp_mux[i] = reg_rsp_i[i];  // real slave
    end
    else
    begin : g_free
      // empty region, acked in the strobe cycle with zero data
      assign rsp_mux[i] = '{rdata: '0, err: 1'b0, ack: strobe};
    end
  end

  // master holds the address until ack, so the mux stays stable
  assign sys_rsp_o = rsp_mux[region];

endmodule

// File: design/housekeeping.sv
////////////////////////////////////////
// housekeeping regs: id, loopback, leds,
// dc level per dac channel
////////////////////////////////////////
`timescale 1ns/1ps
`include "rp_settings.svh"

module housekeeping (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_bus_pkg::sys_req_t     bus_req_i,   // region 0 request
  output rp_bus_pkg::sys_rsp_t     bus_rsp_o,
  output logic                     loop_en_o,   // digital loopback on
  output rp_analog_pkg::smp_pair_t dac_lvl_o,   // dc level to both dacs
  output rp_analog_pkg::led_t      led_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  logic [`RP_REG_SEL_LSB-1:0] ofs;       // offset inside the region
  logic                       loop_en_q;
  led_t                       led_q;
  smp_pair_t                  lvl_q;
  logic [`RP_BUS_DW-1:0]      rd_word;   // read mux
  logic [`RP_BUS_DW-1:0]      rdata_q;
  logic                       ack_q;

  assign ofs = bus_req_i.addr[`RP_REG_SEL_LSB-1:0];

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      loop_en_q <= 1'b0;
      led_q     <= '0;
      lvl_q     <= '0;  // both dac pads at mid code
    end
    else if (bus_req_i.wen)
    begin
      case (ofs)
        `RP_HK_LOOP_OFS:  loop_en_q <= bus_req_i.wdata[0];
        `RP_HK_LED_OFS:   led_q     <= bus_req_i.wdata[`RP_LED_W-1:0];
        `RP_HK_LVL_A_OFS: lvl_q.a   <= smp_t'(bus_req_i.wdata[`RP_SMP_W-1:0]);
        `RP_HK_LVL_B_OFS: lvl_q.b   <= smp_t'(bus_req_i.wdata[`RP_SMP_W-1:0]);
        default:          ;  // id and holes, write dropped but acked
      endcase
    end
  end

  ////////////////////////////////////////
  // read back
  ////////////////////////////////////////

  always_comb
  begin
    case (ofs)
      `RP_HK_ID_OFS:    rd_word = `RP_HK_ID;
      `RP_HK_LOOP_OFS:  rd_word = `RP_BUS_DW'(loop_en_q);
      `RP_HK_LED_OFS:   rd_word = `RP_BUS_DW'(led_q);
      `RP_HK_LVL_A_OFS: rd_word = smp_to_word(lvl_q.a);  // sign extended
      `RP_HK_LVL_B_OFS: rd_word = smp_to_word(lvl_q.b);
      default:          rd_word = '0;  // unmapped reads as zero
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
      rdata_q <= rd_word;
  end

  // one cycle answer for reads and writes
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus_req_i.wen | bus_req_i.ren;
  end

  assign bus_rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};
  assign loop_en_o = loop_en_q;
  assign dac_lvl_o = lvl_q;
  assign led_o     = led_q;

endmodule

// File: analog/adc_frontend.sv
////////////////////////////////////////
// adc pad register, neg slope conversion,
// loopback select
////////////////////////////////////////
`timescale 1ns/1ps
`include "rp_settings.svh"

module adc_frontend (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  input  logic [`RP_ADC_PAD_W-1:0]    adc_dat_a_i,  // ch a pads
  input  logic [`RP_ADC_PAD_W-1:0]    adc_dat_b_i,  // ch b pads
  input  logic                        loop_en_i,    // take dac level instead
  input  rp_analog_pkg::smp_pair_t    dac_lvl_i,
  output rp_analog_pkg::smp_pair_t    adc_smp_o     // two's complement samples
);

  import rp_analog_pkg::*;

  pad_pair_t pad_q;     // input register, ideally packed into the IOB
  smp_pair_t adc_conv;  // converted pad samples

  ////////////////////////////////////////
  // pad capture
  ////////////////////////////////////////

  // top 14 bits only, the low 2 are reserved for a 16 bit part
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      pad_q <= '0;
    else
    begin
      pad_q.a <= adc_dat_a_i[`RP_ADC_PAD_W-1 -: `RP_SMP_W];
      pad_q.b <= adc_dat_b_i[`RP_ADC_PAD_W-1 -: `RP_SMP_W];
    end
  end

  ////////////////////////////////////////
  // conversion and loopback
  ////////////////////////////////////////

  // negative slope: msb kept, rest inverted
  assign adc_conv.a = pad_to_smp(pad_q.a);
  assign adc_conv.b = pad_to_smp(pad_q.b);

  // loopback is combinational, no extra stage
  assign adc_smp_o = loop_en_i ? dac_lvl_i : adc_conv;

endmodule

// File: analog/dac_frontend.sv
////////////////////////////////////////
// dac output register, both channels
////////////////////////////////////////
`timescale 1ns/1ps

module dac_frontend (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_analog_pkg::smp_pair_t dac_lvl_i,  // two's complement levels
  output rp_analog_pkg::pad_pair_t dac_pad_o   // pad code, registered
);

  import rp_analog_pkg::*;

  localparam pad_t PAD_ZERO = smp_to_pad('0);  // 0x1fff, level zero

  pad_pair_t pad_d;  // converted, before the register
  pad_pair_t pad_q;

  // inverse of the adc conversion, same bit flip
  assign pad_d.a = smp_to_pad(dac_lvl_i.a);
  assign pad_d.b = smp_to_pad(dac_lvl_i.b);

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      pad_q.a <= PAD_ZERO;  // dac idles at mid scale
      pad_q.b <= PAD_ZERO;
    end
    else
      pad_q <= pad_d;
  end

  assign dac_pad_o = pad_q;  // both channels in parallel, no interleave

endmodule

// File: analog/adc_monitor.sv
////////////////////////////////////////
// region 1, read only latest adc samples
////////////////////////////////////////
`timescale 1ns/1ps
`include "rp_settings.svh"

module adc_monitor (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_analog_pkg::smp_pair_t adc_smp_i,  // from the adc frontend
  input  rp_bus_pkg::sys_req_t     bus_req_i,
  output rp_bus_pkg::sys_rsp_t     bus_rsp_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  logic [`RP_REG_SEL_LSB-1:0] ofs;
  smp_pair_t                  smp_q;    // snapshot, refreshed every cycle
  logic [`RP_BUS_DW-1:0]      rd_word;
  logic [`RP_BUS_DW-1:0]      rdata_q;
  logic                       ack_q;
  logic                       err_q;    // set for writes

  assign ofs = bus_req_i.addr[`RP_REG_SEL_LSB-1:0];

  always_ff @(posedge adc_clk)
    smp_q <= adc_smp_i;

  ////////////////////////////////////////
  // bus side
  ////////////////////////////////////////

  always_comb
  begin
    case (ofs)
      `RP_MON_A_OFS: rd_word = smp_to_word(smp_q.a);
      `RP_MON_B_OFS: rd_word = smp_to_word(smp_q.b);
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
      rdata_q <= rd_word;
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= bus_req_i.wen | bus_req_i.ren;
      err_q <= bus_req_i.wen;  // region is read only
    end
  end

  assign bus_rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

endmodule

// File: design/rp_top.sv
////////////////////////////////////////
// top level, analog front end and system bus
////////////////////////////////////////
`timescale 1ns/1ps
`include "rp_settings.svh"

module rp_top (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [`RP_ADC_PAD_W-1:0] adc_dat_a_i,  // adc ch a pads
  input  logic [`RP_ADC_PAD_W-1:0] adc_dat_b_i,  // adc ch b pads
  input  rp_bus_pkg::sys_req_t     sys_req_i,    // bus master
  output rp_bus_pkg::sys_rsp_t     sys_rsp_o,
  output rp_analog_pkg::pad_t      dac_dat_a_o,  // dac ch a pads
  output rp_analog_pkg::pad_t      dac_dat_b_o,  // dac ch b pads
  output rp_analog_pkg::led_t      led_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  sys_req_t  reg_req [`RP_REGIONS];  // per region, strobes masked
  sys_rsp_t  reg_rsp [`RP_REGIONS];  // only hk and monitor slots driven
  logic      loop_en;
  smp_pair_t dac_lvl;                // level regs to both frontends
  smp_pair_t adc_smp;
  pad_pair_t dac_pad;

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////

  sys_bus_decoder u_sys_bus_decoder (
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)  // slots 2..7 tied off inside
  );

  housekeeping u_housekeeping (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (reg_req[REG_HK]),
    .bus_rsp_o (reg_rsp[REG_HK]),
    .loop_en_o (loop_en),
    .dac_lvl_o (dac_lvl),
    .led_o     (led_o)
  );

  ////////////////////////////////////////
  // analog front end
  ////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .dac_lvl_i   (dac_lvl),
    .adc_smp_o   (adc_smp)
  );

  dac_frontend u_dac_frontend (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .dac_lvl_i (dac_lvl),
    .dac_pad_o (dac_pad)
  );

  adc_monitor u_adc_monitor (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_smp_i (adc_smp),
    .bus_req_i (reg_req[REG_MON]),
    .bus_rsp_o (reg_rsp[REG_MON])
  );

  // pad pair out to the two dac buses
  assign dac_dat_a_o = dac_pad.a;
  assign dac_dat_b_o = dac_pad.b;

endmodule

// File: dv/rp_top_tb.sv
////////////////////////////////////////
// rp_top testbench, pattern file driven
// bus accesses, lfsr adc pads, dac and led checks
////////////////////////////////////////
`timescale 1ns/1ps
`include "rp_settings.svh"

module rp_top_tb;

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  localparam int          RST_CYC    = 4;
  localparam int          SETTLE_CYC = 16;    // reset release, post reset checks
  localparam int          LINE_CYC   = 8;     // worst case per pattern line
  localparam int          ACK_WAIT   = 4;
  localparam int          HOLD_CYC   = 3;     // pad hold before a monitor read
  localparam logic [16:0] LFSR_SEED  = 17'd72553;
  localparam int          SMP_MID    = (1 << (`RP_SMP_W - 1)) - 1;  // 8191

  logic                     adc_clk;
  logic                     rst_n_i;
  logic [`RP_ADC_PAD_W-1:0] adc_dat_a_i;
  logic [`RP_ADC_PAD_W-1:0] adc_dat_b_i;
  sys_req_t                 sys_req_i;
  sys_rsp_t                 sys_rsp_o;
  pad_t                     dac_dat_a_o;
  pad_t                     dac_dat_b_o;
  led_t                     led_o;

  logic [16:0] lfsr_state  = LFSR_SEED;
  int          cycle_cnt   = 0;
  int          cycle_limit = 1000000;  // replaced once the patterns are read

  // parsed pattern lines
  logic [7:0]  op_q [$];
  logic [31:0] addr_q [$];
  logic [31:0] data_q [$];
  logic [31:0] exp_q [$];

  rp_top dut0 (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_req_i   (sys_req_i),
    .sys_rsp_o   (sys_rsp_o),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // 40 ns period
  end

  always @(posedge adc_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout after %0d cycles, pattern run did not finish", cycle_cnt);
      $display("*** TEST FAILED ***");
      $fatal(1, "run aborted on timeout");
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // fibonacci lfsr, x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val        = {val[30:0], lfsr_state[16]};  // one step per bit
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // negative slope code to value, 0x1fff - code, as a bus word
  function automatic logic [31:0] pad_word(input logic [`RP_ADC_PAD_W-1:0] pad);
    int code;
    int val;
    code = int'(pad[`RP_ADC_PAD_W-1 -: `RP_SMP_W]);  // reserved low bits dropped
    val  = SMP_MID - code;
    return val;
  endfunction

  // one strobe, then wait for ack sampled on the falling edge
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output sys_rsp_t rsp);
    sys_req_t req;
    bit       got;
    req.addr  = addr;
    req.wdata = wdata;
    req.wen   = wr;
    req.ren   = !wr;
    got       = 1'b0;
    rsp       = '0;
    @(posedge adc_clk);
    sys_req_i <= req;
    req.wen = 1'b0;  // strobe lasts one cycle, addr held
    req.ren = 1'b0;
    for (int n = 0; n < ACK_WAIT && !got; n++)
    begin
      @(negedge adc_clk);
      if (sys_rsp_o.ack)
      begin
        rsp = sys_rsp_o;
        got = 1'b1;
      end
      @(posedge adc_clk);
      sys_req_i <= req;
    end
    if (!got)
    begin
      $display("bus slave at address %h never acknowledged", addr);
      $display("*** TEST FAILED ***");
      $fatal(1, "no ack on the system bus");
    end
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_rsp(input string name, input sys_rsp_t exp_rsp,
                           input sys_rsp_t act_rsp, input bit cmp_data);
    if (act_rsp.err !== exp_rsp.err || (cmp_data && act_rsp.rdata !== exp_rsp.rdata))
    begin
      $display("mismatch at %0t: %s expected rdata %h err %0b, actual rdata %h err %0b",
               $time, name, exp_rsp.rdata, exp_rsp.err, act_rsp.rdata, act_rsp.err);
      $display("*** TEST FAILED ***");
      $fatal(1, "bus response check failed");
    end
  endtask

  task automatic check_pad(input string name, input pad_t exp_pad, input pad_t act_pad);
    if (act_pad !== exp_pad)
    begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_pad, act_pad);
      $display("*** TEST FAILED ***");
      $fatal(1, "dac pad check failed");
    end
  endtask

  task automatic check_led(input string name, input led_t exp_led, input led_t act_led);
    if (act_led !== exp_led)
    begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_led, act_led);
      $display("*** TEST FAILED ***");
      $fatal(1, "led check failed");
    end
  endtask

  ////////////////////////////////////////
  // pattern lines
  ////////////////////////////////////////

  task automatic read_patterns();
    int         fd;
    string      line;
    logic [7:0] op;
    logic [31:0] addr, data, expv;
    fd = $fopen("dv/rp_top_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the pattern file dv/rp_top_patterns.txt");
      $display("*** TEST FAILED ***");
      $fatal(1, "pattern file missing");
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 1 && line[0] != "#")  // skip blanks and comments
      begin
        if ($sscanf(line, "%c %h %h %h", op, addr, data, expv) == 4)
        begin
          op_q.push_back(op);
          addr_q.push_back(addr);
          data_q.push_back(data);
          exp_q.push_back(expv);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_line(input logic [7:0] op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] expv);
    sys_rsp_t    rsp;
    sys_rsp_t    exp_rsp;
    logic [31:0] rnd_a, rnd_b;
    logic [19:0] ofs;
    ofs           = addr[`RP_REG_SEL_LSB-1:0];
    exp_rsp.rdata = expv;
    exp_rsp.err   = 1'b0;
    exp_rsp.ack   = 1'b1;
    case (op)
      "W":
      begin
        bus_access(1'b1, addr, data, rsp);
        check_rsp("sys_rsp_o", exp_rsp, rsp, 1'b0);
        @(negedge adc_clk);  // dac register one cycle behind the level
        if (addr[`RP_REG_SEL_MSB:`RP_REG_SEL_LSB] == REG_HK)
        begin
          if (ofs == `RP_HK_LED_OFS)
            check_led("led_o", expv[`RP_LED_W-1:0], led_o);
          else if (ofs == `RP_HK_LVL_A_OFS)
            check_pad("dac_dat_a_o", expv[`RP_SMP_W-1:0], dac_dat_a_o);
          else if (ofs == `RP_HK_LVL_B_OFS)
            check_pad("dac_dat_b_o", expv[`RP_SMP_W-1:0], dac_dat_b_o);
        end
      end
      "R":
      begin
        bus_access(1'b0, addr, '0, rsp);
        check_rsp("sys_rsp_o", exp_rsp, rsp, 1'b1);
      end
      "E":
      begin
        bus_access(1'b1, addr, data, rsp);
        exp_rsp.err = 1'b1;
        check_rsp("sys_rsp_o", exp_rsp, rsp, 1'b0);
      end
      "A":
      begin
        draw_bits(`RP_ADC_PAD_W, rnd_a);
        draw_bits(`RP_ADC_PAD_W, rnd_b);
        @(posedge adc_clk);
        adc_dat_a_i <= rnd_a[`RP_ADC_PAD_W-1:0];
        adc_dat_b_i <= rnd_b[`RP_ADC_PAD_W-1:0];
        repeat (HOLD_CYC) @(posedge adc_clk);
        bus_access(1'b0, addr, '0, rsp);
        if (!data[0])  // from the pads, else loopback level in the file
          exp_rsp.rdata = pad_word(addr[2] ? rnd_b[15:0] : rnd_a[15:0]);
        check_rsp("sys_rsp_o", exp_rsp, rsp, 1'b1);
      end
      default:
      begin
        $display("unknown operation '%c' in the pattern file", op);
        $display("*** TEST FAILED ***");
        $fatal(1, "bad pattern line");
      end
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    rst_n_i     = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_req_i   = '0;
    read_patterns();
    cycle_limit = op_q.size() * LINE_CYC + RST_CYC + SETTLE_CYC;
    repeat (RST_CYC) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    @(negedge adc_clk);
    check_led("led_o", '0, led_o);  // reset state
    check_pad("dac_dat_a_o", 14'h1fff, dac_dat_a_o);
    check_pad("dac_dat_b_o", 14'h1fff, dac_dat_b_o);
    for (int i = 0; i < op_q.size(); i++)
      run_line(op_q[i], addr_q[i], data_q[i], exp_q[i]);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: rp_top.f
+incdir+common
common/rp_bus_pkg.sv
common/rp_analog_pkg.sv
design/sys_bus_decoder.sv
design/housekeeping.sv
analog/adc_frontend.sv
analog/dac_frontend.sv
analog/adc_monitor.sv
design/rp_top.sv
dv/rp_top_tb.sv

// File: dv/rp_top_patterns.txt
# op addr data expected, hex; op W write, R read, E write expecting err, A adc check
# W expected is the led or dac pad value after the write; A data 1 expects the column
R 00000000 00000000 52500001
R 00000030 00000000 00000000
R 00000004 00000000 00000000
W 00000030 000000a5 000000a5
R 00000030 00000000 000000a5
W 00000030 ffffff3c 0000003c
R 00000030 00000000 0000003c
R 00000010 00000000 00000000
W 00000000 12345678 00000000
R 00000000 00000000 52500001
A 00100000 00000000 00000000
A 00100004 00000000 00000000
A 00100000 00000000 00000000
A 00100004 00000000 00000000
W 00000040 00000123 00001edc
R 00000040 00000000 00000123
W 00000044 00003f00 000020ff
R 00000044 00000000 ffffff00
W 00000040 ffffe000 00003fff
R 00000040 00000000 ffffe000
W 00000004 00000001 00000000
R 00000004 00000000 00000001
A 00100000 00000001 ffffe000
A 00100004 00000001 ffffff00
W 00000044 00001fff 00000000
A 00100004 00000001 00001fff
W 00000004 00000000 00000000
A 00100000 00000000 00000000
A 00100004 00000000 00000000
R 00200000 00000000 00000000
R 00300004 00000000 00000000
R 00400000 00000000 00000000
R 00500010 00000000 00000000
R 00600000 00000000 00000000
R 00700040 00000000 00000000
E 00100000 00000055 00000000
E 00100004 00000000 00000000
